// ==== tb/ppu_patterns.txt ====
# Write: W target addr data, all hex; target 0 = OAM, 1 = tile, 2 = palette
# Check: C x y rgb, x and y decimal, rgb hex RRGGBB expected in frame 1
# OAM entries 0, 3 and 9 enabled, entry 7 disabled
W 0 0000 840a1010
W 0 0003 880c180c
W 0 0007 040a6464
W 0 0009 8c0ac8c8
# Tile bytes, tile 5 rows 0 and 7, tile 6 row 1
W 1 00a0 00000003
W 1 00bf 000000a5
W 1 00c6 0000000e
# Palette 1 indices 0 3 5 10, palette 2 index 14, palette 3 indices 0 3
W 2 0010 00000123
W 2 0013 000000f0
W 2 0015 00000456
W 2 001a 00000abc
W 2 002e 00000f80
W 2 0030 000009e1
W 2 0033 0000000f
# Background, two pixels under the disabled entry
C 0 0 000000
C 100 50 000000
C 107 57 000000
# Nibble decode of sprite 0
C 16 8 102030
C 17 8 00f000
C 22 15 a0b0c0
C 23 15 405060
# Box edges of sprite 0
C 24 15 000000
C 23 16 000000
C 15 8 000000
C 16 7 000000
# Overlap, entry 3 over entry 0
C 17 13 f08000
# Tile 5 under palette 3
C 200 100 90e010
C 201 100 0000f0
# Last column and last line
C 319 0 000000
C 319 239 000000

// ==== ppu_top.f ====
hdl/ppu_pkg.sv
hdl/raster_counter.sv
hdl/sprite_matcher.sv
hdl/tile_store.sv
hdl/palette_lut.sv
hdl/ppu_top.sv
tb/ppu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f ppu_top.f \
    --top-module ppu_tb -o ppu_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/ppu_sim)
echo "$sim_out"

echo "$sim_out" | grep -qx "test passed" && exit 0 || exit 1

// ==== tb/ppu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_tb;
    import ppu_pkg::*;

    localparam int     CLK_PERIOD   = 8;
    localparam int     RESET_CYCLES = 5;
    localparam int     FRAME_CYCLES = DISP_WIDTH * DISP_HEIGHT;
    localparam int     IDLE_SAMPLES = 4;    // Scan register plus three stages
    localparam longint WATCHDOG_NS  = 3 * FRAME_CYCLES * CLK_PERIOD;  // Two frames used, one spare

    logic        clk;
    logic        reset;
    logic        cfg_write;
    cfg_target_t cfg_target;
    cfg_addr_t   cfg_addr;
    cfg_data_t   cfg_data;
    channel_t    pixel_r;
    channel_t    pixel_g;
    channel_t    pixel_b;
    coord_x_t    pixel_x;
    coord_y_t    pixel_y;
    logic        pixel_valid;

    // Tables filled from the pattern file
    logic [1:0]  wr_tgt [$];
    logic [31:0] wr_addr [$];
    logic [31:0] wr_data [$];
    int          ck_x [$];
    int          ck_y [$];
    logic [23:0] ck_rgb [$];
    bit          ck_seen [$];

    int errors      = 0;
    int checks      = 0;
    int frame       = 0;     // Output frame, counted at the last pixel
    int exp_x       = 0;
    int exp_y       = 0;
    int idle        = 0;     // Samples after reset before the first pixel
    int reset_edges = 0;
    bit started     = 1'b0;

    ppu_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t ns", name, expected, actual, $time);
        end
    endtask

    task load_patterns;
        int          fd;
        int          c;
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        fd = $fopen("tb/ppu_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the pattern file tb/ppu_patterns.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);    // Rest of the comment line
                    end
                end else if (c == "W") begin
                    n = $fscanf(fd, "%h %h %h", a, b, d);
                    if (n != 3) begin
                        errors++;
                        $display("Malformed write line in the pattern file");
                    end
                    wr_tgt.push_back(a[1:0]);
                    wr_addr.push_back(b);
                    wr_data.push_back(d);
                end else if (c == "C") begin
                    n = $fscanf(fd, "%d %d %h", a, b, d);
                    if (n != 3) begin
                        errors++;
                        $display("Malformed checkpoint line in the pattern file");
                    end
                    ck_x.push_back(a);
                    ck_y.push_back(b);
                    ck_rgb.push_back(d[23:0]);
                    ck_seen.push_back(1'b0);
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // One write strobe per cycle
    task apply_writes;
        for (int i = 0; i < wr_tgt.size(); i++) begin
            @(negedge clk);
            cfg_write  = 1'b1;
            cfg_target = cfg_target_t'(wr_tgt[i]);
            cfg_addr   = cfg_addr_t'(wr_addr[i]);
            cfg_data   = wr_data[i];
        end
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    task check_pixel;
        check_value("pixel_x", exp_x, pixel_x);
        check_value("pixel_y", exp_y, pixel_y);
        if (frame == 1) begin    // Memories settled by now
            for (int i = 0; i < ck_x.size(); i++) begin
                if (ck_x[i] == pixel_x && ck_y[i] == pixel_y) begin
                    check_value("pixel_rgb", ck_rgb[i], {pixel_r, pixel_g, pixel_b});
                    ck_seen[i] = 1'b1;
                end
            end
        end
        // --------------------
        // Next raster position
        if (exp_x == DISP_WIDTH - 1) begin
            exp_x = 0;
            if (exp_y == DISP_HEIGHT - 1) begin
                exp_y = 0;
                frame++;
            end else begin
                exp_y++;
            end
        end else begin
            exp_x++;
        end
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(posedge clk) begin
        if (reset) begin
            if (reset_edges > 0) begin
                check_value("pixel_valid", 0, pixel_valid);   // Cleared by the first edge
                check_value("pixel_rgb", 0, {pixel_r, pixel_g, pixel_b});
            end
            reset_edges++;
        end else begin
            if (pixel_valid && !started) begin
                started = 1'b1;
                check_value("pixel_valid delay", IDLE_SAMPLES, idle);
            end
            if (!started) begin
                idle++;
                check_value("pixel_rgb", 0, {pixel_r, pixel_g, pixel_b});  // Black until first pixel
            end else if (!pixel_valid) begin
                check_value("pixel_valid", 1, pixel_valid);  // Raster never stalls
            end else begin
                check_pixel();
            end
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        cfg_write  = 1'b0;
        cfg_target = CFG_OAM;
        cfg_addr   = '0;
        cfg_data   = '0;
        load_patterns();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        apply_writes();                        // Still early in frame 0
        wait (frame == 2);
        foreach (ck_seen[i]) begin
            if (!ck_seen[i]) begin
                errors++;
                $display("Checkpoint (%0d,%0d) never appeared in frame 1", ck_x[i], ck_y[i]);
            end
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, frame 1 never completed", WATCHDOG_NS);
        $display("%0d errors in %0d checks", errors, checks);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/ppu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_top (
    input  wire logic                 clk,
    input  wire logic                 reset,
    // Write port, shared by all three memories
    input  wire logic                 cfg_write,
    input  ppu_pkg::cfg_target_t      cfg_target,
    input  ppu_pkg::cfg_addr_t        cfg_addr,
    input  ppu_pkg::cfg_data_t        cfg_data,
    // Pixel out, three cycles behind the scan
    output ppu_pkg::channel_t         pixel_r,
    output ppu_pkg::channel_t         pixel_g,
    output ppu_pkg::channel_t         pixel_b,
    output ppu_pkg::coord_x_t         pixel_x,
    output ppu_pkg::coord_y_t         pixel_y,
    output logic                      pixel_valid
);

    // --------------------
    // Stage wires
    // --------------------
    ppu_pkg::coord_x_t   scan_x;
    ppu_pkg::coord_y_t   scan_y;
    logic                scan_valid;

    logic                m_hit;
    ppu_pkg::tile_idx_t  m_tile;
    ppu_pkg::pal_idx_t   m_pal;
    ppu_pkg::local_t     m_local_x;
    ppu_pkg::local_t     m_local_y;
    ppu_pkg::coord_x_t   m_x;
    ppu_pkg::coord_y_t   m_y;
    logic                m_valid;

    logic                t_hit;
    ppu_pkg::pal_idx_t   t_pal;
    ppu_pkg::pix_idx_t   t_pix;
    ppu_pkg::coord_x_t   t_x;
    ppu_pkg::coord_y_t   t_y;
    logic                t_valid;

    raster_counter u_raster (
        .clk, .reset, .scan_x, .scan_y, .scan_valid
    );

    sprite_matcher u_match (   // Stage 1
        .clk, .reset, .cfg_write, .cfg_target, .cfg_addr, .cfg_data,
        .scan_x, .scan_y, .scan_valid,
        .m_hit, .m_tile, .m_pal, .m_local_x, .m_local_y, .m_x, .m_y, .m_valid
    );

    tile_store u_tile (        // Stage 2
        .clk, .reset, .cfg_write, .cfg_target, .cfg_addr, .cfg_data,
        .m_hit, .m_tile, .m_pal, .m_local_x, .m_local_y, .m_x, .m_y, .m_valid,
        .t_hit, .t_pal, .t_pix, .t_x, .t_y, .t_valid
    );

    palette_lut u_pal (        // Stage 3
        .clk, .reset, .cfg_write, .cfg_target, .cfg_addr, .cfg_data,
        .t_hit, .t_pal, .t_pix, .t_x, .t_y, .t_valid,
        .pixel_r, .pixel_g, .pixel_b, .pixel_x, .pixel_y, .pixel_valid
    );

endmodule

`default_nettype wire

// ==== hdl/palette_lut.sv ====
`timescale 1ns/100ps
`default_nettype none

module palette_lut (
    input  wire logic                 clk,
    input  wire logic                 reset,
    // Write port
    input  wire logic                 cfg_write,
    input  ppu_pkg::cfg_target_t      cfg_target,
    input  ppu_pkg::cfg_addr_t        cfg_addr,
    input  ppu_pkg::cfg_data_t        cfg_data,
    // From tile_store
    input  wire logic                 t_hit,
    input  ppu_pkg::pal_idx_t         t_pal,
    input  ppu_pkg::pix_idx_t         t_pix,
    input  ppu_pkg::coord_x_t         t_x,
    input  ppu_pkg::coord_y_t         t_y,
    input  wire logic                 t_valid,
    // Pixel out
    output ppu_pkg::channel_t         pixel_r,
    output ppu_pkg::channel_t         pixel_g,
    output ppu_pkg::channel_t         pixel_b,
    output ppu_pkg::coord_x_t         pixel_x,
    output ppu_pkg::coord_y_t         pixel_y,
    output logic                      pixel_valid
);
    import ppu_pkg::*;

    color12_t   pal_mem [NUM_PALETTES * PALETTE_COLORS];  // palette*16 + index
    color12_t   color;

    // --------------------
    // Palette write
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PALETTES * PALETTE_COLORS; i++) begin
                pal_mem[i] <= '0;
            end
        end else if (cfg_write && cfg_target == CFG_PALETTE) begin
            pal_mem[cfg_addr[PAL_AW-1:0]] <= cfg_data[11:0];
        end
    end

    assign color = pal_mem[{t_pal, t_pix}];   // Index 0 is a real colour

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_r     <= '0;
            pixel_g     <= '0;
            pixel_b     <= '0;
            pixel_valid <= 1'b0;
        end else begin
            pixel_r     <= t_hit ? {color[11:8], 4'h0} : '0;   // No sprite, black
            pixel_g     <= t_hit ? {color[7:4], 4'h0}  : '0;
            pixel_b     <= t_hit ? {color[3:0], 4'h0}  : '0;
            pixel_valid <= t_valid;
        end
    end

    always_ff @(posedge clk) begin
        pixel_x <= t_x;
        pixel_y <= t_y;
    end

    a_pal_addr: assert property (@(posedge clk) disable iff (reset)
        (cfg_write && cfg_target == CFG_PALETTE)
            |-> (cfg_addr < NUM_PALETTES * PALETTE_COLORS))
        else $error("Palette write beyond last colour");

endmodule

`default_nettype wire

// ==== hdl/tile_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module tile_store (
    input  wire logic                 clk,
    input  wire logic                 reset,
    // Write port
    input  wire logic                 cfg_write,
    input  ppu_pkg::cfg_target_t      cfg_target,
    input  ppu_pkg::cfg_addr_t        cfg_addr,
    input  ppu_pkg::cfg_data_t        cfg_data,
    // From sprite_matcher
    input  wire logic                 m_hit,
    input  ppu_pkg::tile_idx_t        m_tile,
    input  ppu_pkg::pal_idx_t         m_pal,
    input  ppu_pkg::local_t           m_local_x,
    input  ppu_pkg::local_t           m_local_y,
    input  ppu_pkg::coord_x_t         m_x,
    input  ppu_pkg::coord_y_t         m_y,
    input  wire logic                 m_valid,
    // To palette_lut
    output logic                      t_hit,
    output ppu_pkg::pal_idx_t         t_pal,
    output ppu_pkg::pix_idx_t         t_pix,
    output ppu_pkg::coord_x_t         t_x,
    output ppu_pkg::coord_y_t         t_y,
    output logic                      t_valid
);
    import ppu_pkg::*;

    logic [7:0]         tile_mem [TILE_COUNT * TILE_BYTES];  // Two pixels per byte
    logic [TILE_AW-1:0] rd_addr;
    logic [7:0]         rd_byte;

    always_ff @(posedge clk) begin
        if (cfg_write && cfg_target == CFG_TILE) begin
            tile_mem[cfg_addr] <= cfg_data[7:0];
        end
    end

    // tile*32 + row*4 + x/2, plain concatenation
    assign rd_addr = {m_tile, m_local_y, m_local_x[2:1]};
    assign rd_byte = tile_mem[rd_addr];

    // --------------------
    // Stage register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            t_hit   <= 1'b0;
            t_valid <= 1'b0;
        end else begin
            t_hit   <= m_hit;
            t_valid <= m_valid;
        end
    end

    always_ff @(posedge clk) begin
        t_pix <= m_local_x[0] ? rd_byte[3:0] : rd_byte[7:4];  // Even pixel in high nibble
        t_pal <= m_pal;
        t_x   <= m_x;
        t_y   <= m_y;
    end

endmodule

`default_nettype wire

// ==== hdl/sprite_matcher.sv ====
`timescale 1ns/100ps
`default_nettype none

module sprite_matcher (
    input  wire logic                 clk,
    input  wire logic                 reset,
    // Write port
    input  wire logic                 cfg_write,
    input  ppu_pkg::cfg_target_t      cfg_target,
    input  ppu_pkg::cfg_addr_t        cfg_addr,
    input  ppu_pkg::cfg_data_t        cfg_data,
    // Scan position
    input  ppu_pkg::coord_x_t         scan_x,
    input  ppu_pkg::coord_y_t         scan_y,
    input  wire logic                 scan_valid,
    // Winning sprite, one cycle later
    output logic                      m_hit,
    output ppu_pkg::tile_idx_t        m_tile,
    output ppu_pkg::pal_idx_t         m_pal,
    output ppu_pkg::local_t           m_local_x,
    output ppu_pkg::local_t           m_local_y,
    output ppu_pkg::coord_x_t         m_x,
    output ppu_pkg::coord_y_t         m_y,
    output logic                      m_valid
);
    import ppu_pkg::*;

    // OAM record, bit 31 down to bit 0
    typedef struct packed {
        logic      en;     // Bit 31
        logic [1:0] rsvd;  // Flip bits, not used
        pal_idx_t  pal;
        tile_idx_t tile;
        coord_y_t  y;
        coord_x_t  x;
    } oam_entry_t;

    oam_entry_t               oam [MAX_OBJECTS];
    logic [MAX_OBJECTS-1:0]   hit_vec;    // One bit per entry
    logic [OAM_AW-1:0]        win_idx;
    oam_entry_t               win;

    // --------------------
    // OAM write
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MAX_OBJECTS; i++) begin
                oam[i] <= '0;              // All disabled
            end
        end else if (cfg_write && cfg_target == CFG_OAM) begin
            oam[cfg_addr[OAM_AW-1:0]] <= cfg_data;
        end
    end

    // --------------------
    // Box test per entry
    // --------------------
    for (genvar i = 0; i < MAX_OBJECTS; i++) begin : g_obj
        logic [9:0] dx;   // One extra bit so left of box never wraps into it
        logic [8:0] dy;
        assign dx = {1'b0, scan_x} - {1'b0, oam[i].x};
        assign dy = {1'b0, scan_y} - {1'b0, oam[i].y};
        assign hit_vec[i] = oam[i].en && (dx < 10'(SPRITE_SIZE)) && (dy < 9'(SPRITE_SIZE));
    end

    // Highest-numbered hit wins, later iterations override
    always_comb begin
        win_idx = '0;
        for (int i = 0; i < MAX_OBJECTS; i++) begin
            if (hit_vec[i]) begin
                win_idx = OAM_AW'(i);
            end
        end
    end

    assign win = oam[win_idx];

    // --------------------
    // Stage register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            m_hit   <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            m_hit   <= scan_valid && (hit_vec != '0);
            m_valid <= scan_valid;
        end
    end

    always_ff @(posedge clk) begin
        m_tile    <= win.tile;
        m_pal     <= win.pal;
        m_local_x <= local_t'(scan_x - win.x);   // Low bits of the offset
        m_local_y <= local_t'(scan_y - win.y);
        m_x       <= scan_x;
        m_y       <= scan_y;
    end

    a_oam_addr: assert property (@(posedge clk) disable iff (reset)
        (cfg_write && cfg_target == CFG_OAM) |-> (cfg_addr < MAX_OBJECTS))
        else $error("OAM write beyond last entry");

endmodule

`default_nettype wire

// ==== hdl/raster_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module raster_counter (
    input  wire logic              clk,
    input  wire logic              reset,
    output ppu_pkg::coord_x_t      scan_x,
    output ppu_pkg::coord_y_t      scan_y,
    output logic                   scan_valid
);
    import ppu_pkg::*;

    // Position only moves once valid is up, so (0,0) is presented first
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_x     <= '0;
            scan_y     <= '0;
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= 1'b1;
            if (scan_valid) begin
                if (scan_x == coord_x_t'(DISP_WIDTH - 1)) begin
                    scan_x <= '0;                         // End of line
                    if (scan_y == coord_y_t'(DISP_HEIGHT - 1)) begin
                        scan_y <= '0;                     // End of frame
                    end else begin
                        scan_y <= scan_y + 1'b1;
                    end
                end else begin
                    scan_x <= scan_x + 1'b1;
                end
            end
        end
    end

    // Column stays inside the visible line
    a_x_range: assert property (@(posedge clk) disable iff (reset)
        scan_x < DISP_WIDTH)
        else $error("scan_x left the visible line");

endmodule

`default_nettype wire

// ==== hdl/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

    // --------------------
    // Display geometry
    // --------------------
    localparam int DISP_WIDTH     = 320;   // Visible pixels per line
    localparam int DISP_HEIGHT    = 240;   // Lines per frame

    // --------------------
    // Memory sizes
    // --------------------
    localparam int MAX_OBJECTS    = 16;    // OAM entries
    localparam int SPRITE_SIZE    = 8;     // Sprite edge in pixels
    localparam int TILE_COUNT     = 512;
    localparam int TILE_BYTES     = 32;    // 8x8 at 4 bpp
    localparam int NUM_PALETTES   = 8;
    localparam int PALETTE_COLORS = 16;

    // Address widths derived from the sizes above
    localparam int OAM_AW  = $clog2(MAX_OBJECTS);
    localparam int TILE_AW = $clog2(TILE_COUNT * TILE_BYTES);       // 14 bits
    localparam int PAL_AW  = $clog2(NUM_PALETTES * PALETTE_COLORS); // 7 bits

    // --------------------
    // Field types
    // --------------------
    typedef logic [8:0]  coord_x_t;   // Screen X
    typedef logic [7:0]  coord_y_t;   // Screen Y
    typedef logic [8:0]  tile_idx_t;
    typedef logic [2:0]  pal_idx_t;
    typedef logic [3:0]  pix_idx_t;   // Colour index in a palette
    typedef logic [2:0]  local_t;     // Position inside a sprite
    typedef logic [11:0] color12_t;   // 4:4:4 RGB as stored
    typedef logic [7:0]  channel_t;   // One output channel

    // Write port
    typedef enum logic [1:0] {
        CFG_OAM,
        CFG_TILE,
        CFG_PALETTE
    } cfg_target_t;

    typedef logic [TILE_AW-1:0] cfg_addr_t;  // Widest target is tile memory
    typedef logic [31:0]        cfg_data_t;

endpackage

`default_nettype wire
